//--- internalDataflow.f
+incdir+include
src/cpuPkg.sv
src/aluIf.sv
src/internalBus.sv
src/busBridge.sv
src/programCounterLogic.sv
src/alu.sv
src/processStatusRegister.sv
src/internalDataflow.sv
dv/internalDataflow_asserts.sv
dv/tb_internalDataflow.sv

//--- Bender.yml
package:
  name: internalDataflow

sources:
  - include_dirs:
      - include
    files:
      - src/cpuPkg.sv
      - src/aluIf.sv
      - src/internalBus.sv
      - src/busBridge.sv
      - src/programCounterLogic.sv
      - src/alu.sv
      - src/processStatusRegister.sv
      - src/internalDataflow.sv
      - target: test
        files:
          - dv/internalDataflow_asserts.sv
          - dv/tb_internalDataflow.sv

//--- dv/tb_internalDataflow.sv
`include "cpu_params.svh"

module tb_internalDataflow;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int directedCycles = 70; // Upper bound, reset and flush included
    localparam int randomBytes = 200;

    logic clk;
    logic arstN;
    ctrlWord_t flags;
    dataByte_t externalDBRead;
    logic freeCarry;
    dataByte_t externalDBWrite;
    dataByte_t addrLow;
    dataByte_t addrHigh;
    dataByte_t psrToController;
    logic aluCarryOut;
    int seed;
    int totalErrs;

    function automatic ctrlWord_t flagMask(int idx);
        return ctrlWord_t'(1) << idx;
    endfunction

    localparam ctrlWord_t loadDorData = flagMask(`FLAG_DB_FROM_DATA) | flagMask(`FLAG_LOAD_DOR);
    localparam ctrlWord_t loadDorIdle = flagMask(`FLAG_LOAD_DOR);
    localparam ctrlWord_t bridgeToAcc = flagMask(`FLAG_ADH_FROM_DATA) |
                                       flagMask(`FLAG_ADH_TO_SB) | flagMask(`FLAG_LOAD_ACC);
    localparam ctrlWord_t accToDor = flagMask(`FLAG_DB_FROM_ACC) | flagMask(`FLAG_LOAD_DOR);
    localparam ctrlWord_t aluAddLoad = flagMask(`FLAG_SB_FF) | flagMask(`FLAG_A_FROM_SB) |
                                      flagMask(`FLAG_B_FROM_DB) | flagMask(`FLAG_DB_FROM_DATA) |
                                      flagMask(`FLAG_ALU_ADD) | flagMask(`FLAG_CARRY_FREE) |
                                      flagMask(`FLAG_LOAD_ALU);
    localparam ctrlWord_t aluToAbl = flagMask(`FLAG_ADL_FROM_ALU) | flagMask(`FLAG_LOAD_ABL);
    localparam ctrlWord_t psrLoad = flagMask(`FLAG_DB_FROM_DATA) | flagMask(`FLAG_PSR_FROM_DB);
    localparam ctrlWord_t pcIncOnly = flagMask(`FLAG_PC_INC);
    localparam ctrlWord_t pcWalk = flagMask(`FLAG_PC_INC) | flagMask(`FLAG_ADL_FROM_PCL) |
                                  flagMask(`FLAG_ADH_FROM_PCH) | flagMask(`FLAG_LOAD_ABL) |
                                  flagMask(`FLAG_LOAD_ABH);

    internalDataflow dut_i (.*);

    bind internalDataflow internalDataflow_asserts asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic driveCycle(input ctrlWord_t f, input dataByte_t d, input logic c);
        @(posedge clk);
        flags <= f;
        externalDBRead <= d;
        freeCarry <= c;
    endtask

    initial begin
        #((directedCycles + randomBytes * 4) * 10 * 2);
        $display("Timeout: stimulus did not complete before the watchdog expired");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int rnd;
        dataByte_t data;
        seed = 32'h3090b910;
        arstN = 1'b0;
        flags = '0;
        externalDBRead = 8'h00;
        freeCarry = 1'b0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        flags <= pcIncOnly; // PC reaches 16'hAABC before the walk starts
        repeat (20) driveCycle(pcWalk, 8'h00, 1'b0);

        driveCycle(loadDorData, 8'hA5, 1'b0);
        driveCycle(loadDorData, 8'h3C, 1'b0);
        driveCycle(loadDorIdle, 8'h00, 1'b0);

        // ADL presets load ABL, ADH presets load ABH
        for (int i = `FLAG_ADL_FA; i <= `FLAG_ADH_FF; i++) begin
            driveCycle(flagMask(i) | flagMask(i <= `FLAG_ADL_00 ? `FLAG_LOAD_ABL : `FLAG_LOAD_ABH),
                8'h00, 1'b0);
        end

        driveCycle(bridgeToAcc, 8'h96, 1'b0);
        driveCycle(accToDor, 8'h00, 1'b0);
        driveCycle(bridgeToAcc, 8'h01, 1'b0);
        driveCycle(accToDor, 8'hFF, 1'b0);

        // Corner cases of the carry out of 8'hFF plus data
        driveCycle(aluAddLoad, 8'h00, 1'b0);
        driveCycle(aluToAbl, 8'h00, 1'b0);
        driveCycle(aluAddLoad, 8'h00, 1'b1);
        driveCycle(aluToAbl, 8'h00, 1'b0);
        driveCycle(aluAddLoad, 8'h01, 1'b0);
        driveCycle(aluToAbl, 8'h00, 1'b0);
        driveCycle(aluAddLoad, 8'h80, 1'b1);
        driveCycle(aluToAbl, 8'h00, 1'b0);

        driveCycle(psrLoad, 8'h00, 1'b0);
        driveCycle(psrLoad, 8'hFF, 1'b0);
        driveCycle(psrLoad, 8'h5A, 1'b0);
        driveCycle(psrLoad, 8'h81, 1'b0);

        for (int n = 0; n < randomBytes; n++) begin
            rnd = $random(seed);
            data = rnd[7:0];
            case (rnd[10:9]) // Pattern pick
                2'd0: driveCycle(loadDorData, data, rnd[8]);
                2'd1: begin
                    driveCycle(aluAddLoad, data, rnd[8]);
                    driveCycle(aluToAbl, ~data, 1'b0);
                end
                2'd2: begin
                    driveCycle(bridgeToAcc, data, rnd[8]);
                    driveCycle(accToDor, ~data, 1'b0);
                end
                default: driveCycle(psrLoad, data, rnd[8]);
            endcase
        end

        repeat (3) driveCycle('0, 8'h00, 1'b0); // Let the last checks complete

        totalErrs = dut_i.asserts_i.resetErrs + dut_i.asserts_i.loadErrs +
                    dut_i.asserts_i.presetErrs + dut_i.asserts_i.bridgeErrs +
                    dut_i.asserts_i.aluErrs + dut_i.asserts_i.pcErrs + dut_i.asserts_i.psrErrs;
        $display("Errors reset %0d load %0d preset %0d bridge %0d alu %0d pc %0d psr %0d total %0d",
            dut_i.asserts_i.resetErrs, dut_i.asserts_i.loadErrs, dut_i.asserts_i.presetErrs,
            dut_i.asserts_i.bridgeErrs, dut_i.asserts_i.aluErrs, dut_i.asserts_i.pcErrs,
            dut_i.asserts_i.psrErrs, totalErrs);
        if (totalErrs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- dv/internalDataflow_asserts.sv
`include "cpu_params.svh"

module internalDataflow_asserts (
    input logic clk,
    input logic arstN,
    input cpuPkg::ctrlWord_t flags,
    input cpuPkg::dataByte_t externalDBRead,
    input logic freeCarry,
    input cpuPkg::dataByte_t externalDBWrite,
    input cpuPkg::dataByte_t addrLow,
    input cpuPkg::dataByte_t addrHigh,
    input cpuPkg::dataByte_t psrToController,
    input logic aluCarryOut
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    function automatic ctrlWord_t flagMask(int idx);
        return ctrlWord_t'(1) << idx;
    endfunction

    localparam ctrlWord_t loadDorData = flagMask(`FLAG_DB_FROM_DATA) | flagMask(`FLAG_LOAD_DOR);
    localparam ctrlWord_t loadDorIdle = flagMask(`FLAG_LOAD_DOR); // DB left precharged
    localparam ctrlWord_t bridgeToAcc = flagMask(`FLAG_ADH_FROM_DATA) |
                                       flagMask(`FLAG_ADH_TO_SB) | flagMask(`FLAG_LOAD_ACC);
    localparam ctrlWord_t accToDor = flagMask(`FLAG_DB_FROM_ACC) | flagMask(`FLAG_LOAD_DOR);
    localparam ctrlWord_t aluAddLoad = flagMask(`FLAG_SB_FF) | flagMask(`FLAG_A_FROM_SB) |
                                      flagMask(`FLAG_B_FROM_DB) | flagMask(`FLAG_DB_FROM_DATA) |
                                      flagMask(`FLAG_ALU_ADD) | flagMask(`FLAG_CARRY_FREE) |
                                      flagMask(`FLAG_LOAD_ALU);
    localparam ctrlWord_t aluToAbl = flagMask(`FLAG_ADL_FROM_ALU) | flagMask(`FLAG_LOAD_ABL);
    localparam ctrlWord_t psrLoad = flagMask(`FLAG_DB_FROM_DATA) | flagMask(`FLAG_PSR_FROM_DB);
    localparam ctrlWord_t pcIncOnly = flagMask(`FLAG_PC_INC);
    localparam ctrlWord_t pcWalk = flagMask(`FLAG_PC_INC) | flagMask(`FLAG_ADL_FROM_PCL) |
                                  flagMask(`FLAG_ADH_FROM_PCH) | flagMask(`FLAG_LOAD_ABL) |
                                  flagMask(`FLAG_LOAD_ABH);

    // Preset flag, expected bus value; the last three sit on ADH
    localparam int presetFlag [10] = '{`FLAG_ADL_FA, `FLAG_ADL_FB, `FLAG_ADL_FC, `FLAG_ADL_FD,
        `FLAG_ADL_FE, `FLAG_ADL_FF, `FLAG_ADL_00, `FLAG_ADH_00, `FLAG_ADH_01, `FLAG_ADH_FF};
    localparam dataByte_t presetValue [10] = '{8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'hFF,
        8'h00, 8'h00, 8'h01, 8'hFF};

    int resetErrs = 0;
    int loadErrs = 0;
    int presetErrs = 0;
    int bridgeErrs = 0;
    int aluErrs = 0;
    int pcErrs = 0;
    int psrErrs = 0;

    dataByte_t data1; // Input byte one cycle back
    dataByte_t data2; // Two cycles back
    logic carry1;
    logic carry2;
    pcWord_t addrPrev;
    dataByte_t aluSumExp;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            data1 <= '0;
            data2 <= '0;
            carry1 <= 1'b0;
            carry2 <= 1'b0;
            addrPrev <= '0;
        end else begin
            data1 <= externalDBRead;
            data2 <= data1;
            carry1 <= freeCarry;
            carry2 <= carry1;
            addrPrev <= {addrHigh, addrLow};
        end
    end

    assign aluSumExp = data2 + 8'hFF + carry2; // Wraps at 256

    resetValues: assert property (@(posedge clk) !arstN ##1 !arstN |->
            addrLow == 8'h00 && addrHigh == 8'h00 && externalDBWrite == 8'h00 &&
            psrToController == 8'h24)
        else begin
            resetErrs++;
            $error("ERR reset addrLow %h addrHigh %h externalDBWrite %h psrToController %h",
                $sampled(addrLow), $sampled(addrHigh), $sampled(externalDBWrite),
                $sampled(psrToController));
        end

    dorFromData: assert property (@(posedge clk) disable iff (!arstN)
            flags == loadDorData |=> externalDBWrite == data1)
        else begin
            loadErrs++;
            $error("ERR externalDBWrite exp %h got %h", $sampled(data1),
                $sampled(externalDBWrite));
        end

    dorPrecharge: assert property (@(posedge clk) disable iff (!arstN)
            flags == loadDorIdle |=> externalDBWrite == 8'hFF)
        else begin
            loadErrs++;
            $error("ERR externalDBWrite exp %h got %h", 8'hFF, $sampled(externalDBWrite));
        end

    for (genvar i = 0; i < 10; i++) begin : presetChecks
        localparam bit toHigh = (i >= 7);
        localparam ctrlWord_t pattern = flagMask(presetFlag[i]) |
                                        flagMask(toHigh ? `FLAG_LOAD_ABH : `FLAG_LOAD_ABL);

        presetLoad: assert property (@(posedge clk) disable iff (!arstN)
                flags == pattern |=> (toHigh ? addrHigh : addrLow) == presetValue[i])
            else begin
                presetErrs++;
                $error("ERR %s exp %h got %h", toHigh ? "addrHigh" : "addrLow", presetValue[i],
                    toHigh ? $sampled(addrHigh) : $sampled(addrLow));
            end
    end

    // ADH through the bridge into ACC, then out through DB
    bridgePath: assert property (@(posedge clk) disable iff (!arstN)
            flags == bridgeToAcc ##1 flags == accToDor |=> externalDBWrite == data2)
        else begin
            bridgeErrs++;
            $error("ERR externalDBWrite exp %h got %h", $sampled(data2),
                $sampled(externalDBWrite));
        end

    // 8'hFF plus data carries unless both data and carry in are zero
    aluCarry: assert property (@(posedge clk) disable iff (!arstN)
            flags == aluAddLoad |-> aluCarryOut == (externalDBRead != 8'h00 || freeCarry))
        else begin
            aluErrs++;
            $error("ERR aluCarryOut exp %h got %h",
                $sampled(externalDBRead) != 8'h00 || $sampled(freeCarry), $sampled(aluCarryOut));
        end

    aluHold: assert property (@(posedge clk) disable iff (!arstN)
            flags == aluAddLoad ##1 flags == aluToAbl |=> addrLow == aluSumExp)
        else begin
            aluErrs++;
            $error("ERR addrLow exp %h got %h", $sampled(aluSumExp), $sampled(addrLow));
        end

    pcStart: assert property (@(posedge clk)
            !arstN ##1 (arstN && flags == pcIncOnly) ##1 flags == pcWalk |=>
            {addrHigh, addrLow} == 16'hAABC)
        else begin
            pcErrs++;
            $error("ERR {addrHigh, addrLow} exp %h got %h", 16'hAABC,
                $sampled({addrHigh, addrLow}));
        end

    pcStep: assert property (@(posedge clk) disable iff (!arstN)
            flags == pcWalk ##1 flags == pcWalk |=> {addrHigh, addrLow} == addrPrev + 16'd1)
        else begin
            pcErrs++;
            $error("ERR {addrHigh, addrLow} exp %h got %h", $sampled(addrPrev) + 16'd1,
                $sampled({addrHigh, addrLow}));
        end

    psrFromDb: assert property (@(posedge clk) disable iff (!arstN)
            flags == psrLoad |=> psrToController == (data1 | 8'h20))
        else begin
            psrErrs++;
            $error("ERR psrToController exp %h got %h", $sampled(data1) | 8'h20,
                $sampled(psrToController));
        end

endmodule

//--- src/internalDataflow.sv
`include "cpu_params.svh"

module internalDataflow (
    input logic clk,
    input logic arstN,
    input cpuPkg::ctrlWord_t flags,
    input cpuPkg::dataByte_t externalDBRead,
    input logic freeCarry,
    output cpuPkg::dataByte_t externalDBWrite,
    output cpuPkg::dataByte_t addrLow,
    output cpuPkg::dataByte_t addrHigh,
    output cpuPkg::dataByte_t psrToController,
    output logic aluCarryOut
);
    import cpuPkg::*;

    dataByte_t xReg, yReg, accReg, spReg, aluHoldReg;
    dataByte_t ablReg, abhReg, dorReg;
    pcWord_t pcReg;
    pcWord_t pcNext; // From the PC incrementer
    pcWord_t addrNext; // From the ADH:ADL incrementer

    dataByte_t dbRaw, sbRaw, adhRaw; // Before the bridge
    dataByte_t dbBus, sbBus, adhBus, adlBus;

    dataByte_t adlPresetValue, adhPresetValue;
    logic adlPresetEnable, adhPresetEnable;

    aluIf aluBus();

    // Several presets at once AND like any other sources
    always_comb begin
        adlPresetValue = 8'hFF;
        if (flags[`FLAG_ADL_FA]) adlPresetValue = adlPresetValue & 8'hFA;
        if (flags[`FLAG_ADL_FB]) adlPresetValue = adlPresetValue & 8'hFB;
        if (flags[`FLAG_ADL_FC]) adlPresetValue = adlPresetValue & 8'hFC;
        if (flags[`FLAG_ADL_FD]) adlPresetValue = adlPresetValue & 8'hFD;
        if (flags[`FLAG_ADL_FE]) adlPresetValue = adlPresetValue & 8'hFE;
        if (flags[`FLAG_ADL_00]) adlPresetValue = 8'h00;
        adhPresetValue = 8'hFF;
        if (flags[`FLAG_ADH_00]) adhPresetValue = 8'h00;
        if (flags[`FLAG_ADH_01]) adhPresetValue = adhPresetValue & 8'h01;
    end

    assign adlPresetEnable = |flags[`FLAG_ADL_00:`FLAG_ADL_FA];
    assign adhPresetEnable = flags[`FLAG_ADH_00] | flags[`FLAG_ADH_01];

    internalBus #(.sourceCount(6)) dbBus_i (
        .busSelect({flags[`FLAG_DB_FROM_PSR], flags[`FLAG_DB_FROM_PCH], flags[`FLAG_DB_FROM_PCL],
                    flags[`FLAG_DB_FROM_ACC], flags[`FLAG_DB_FROM_DATA], flags[`FLAG_DB_FF]}),
        .busInputs({psrToController, pcReg[15:8], pcReg[7:0], accReg, externalDBRead, 8'hFF}),
        .busOutput(dbRaw)
    );

    internalBus #(.sourceCount(6)) sbBus_i (
        .busSelect({flags[`FLAG_SB_FROM_X], flags[`FLAG_SB_FROM_Y], flags[`FLAG_SB_FROM_SP],
                    flags[`FLAG_SB_FROM_ALU], flags[`FLAG_SB_FROM_ACC], flags[`FLAG_SB_FF]}),
        .busInputs({xReg, yReg, spReg, aluHoldReg, accReg, 8'hFF}),
        .busOutput(sbRaw)
    );

    internalBus #(.sourceCount(5)) adlBus_i (
        .busSelect({flags[`FLAG_ADL_FROM_SP], flags[`FLAG_ADL_FROM_ALU], flags[`FLAG_ADL_FROM_PCL],
                    flags[`FLAG_ADL_FROM_DATA], adlPresetEnable}),
        .busInputs({spReg, aluHoldReg, pcReg[7:0], externalDBRead, adlPresetValue}),
        .busOutput(adlBus)
    );

    internalBus #(.sourceCount(4)) adhBus_i (
        .busSelect({flags[`FLAG_ADH_FROM_PCH], flags[`FLAG_ADH_FROM_DATA], flags[`FLAG_ADH_FF],
                    adhPresetEnable}),
        .busInputs({pcReg[15:8], externalDBRead, 8'hFF, adhPresetValue}),
        .busOutput(adhRaw)
    );

    busBridge bridge_i (
        .dbIn(dbRaw),
        .sbIn(sbRaw),
        .adhIn(adhRaw),
        .dbOut(dbBus),
        .sbOut(sbBus),
        .adhOut(adhBus),
        .dbToSb(flags[`FLAG_DB_TO_SB]),
        .sbToDb(flags[`FLAG_SB_TO_DB]),
        .sbToAdh(flags[`FLAG_SB_TO_ADH]),
        .adhToSb(flags[`FLAG_ADH_TO_SB])
    );

    programCounterLogic pcIncr_i (
        .pcIn(pcReg),
        .increment(flags[`FLAG_PC_INC]),
        .decrement(flags[`FLAG_PC_DEC]),
        .pcOut(pcNext)
    );

    programCounterLogic addrIncr_i (
        .pcIn({adhBus, adlBus}),
        .increment(flags[`FLAG_PC_INC]),
        .decrement(flags[`FLAG_PC_DEC]),
        .pcOut(addrNext)
    );

    // One-hot op flags encoded for the ALU with add as the default
    always_comb begin
        aluBus.op = `ALU_OP_ADD;
        if (flags[`FLAG_ALU_ADD]) aluBus.op = `ALU_OP_ADD;
        else if (flags[`FLAG_ALU_AND]) aluBus.op = `ALU_OP_AND;
        else if (flags[`FLAG_ALU_EOR]) aluBus.op = `ALU_OP_EOR;
        else if (flags[`FLAG_ALU_OR]) aluBus.op = `ALU_OP_OR;
        else if (flags[`FLAG_ALU_SHR]) aluBus.op = `ALU_OP_SHR;
    end

    assign aluBus.carryIn = flags[`FLAG_CARRY_ONE] | (flags[`FLAG_CARRY_FREE] & freeCarry) |
                            (flags[`FLAG_CARRY_PSR] & psrToController[0]);

    alu alu_i (
        .bus(aluBus.alu),
        .dbIn(dbBus),
        .sbIn(sbBus),
        .adlIn(adlBus),
        .aZero(flags[`FLAG_A_ZERO]),
        .aFromSb(flags[`FLAG_A_FROM_SB]),
        .bFromDb(flags[`FLAG_B_FROM_DB]),
        .bFromNotDb(flags[`FLAG_B_FROM_NOT_DB]),
        .bFromAdl(flags[`FLAG_B_FROM_ADL])
    );

    processStatusRegister psr_i (
        .clk(clk),
        .arstN(arstN),
        .bus(aluBus.psr),
        .dbIn(dbBus),
        .loadAll(flags[`FLAG_PSR_FROM_DB]),
        .cFromAlu(flags[`FLAG_PSR_C_FROM_ALU]),
        .vFromAlu(flags[`FLAG_PSR_V_FROM_ALU]),
        .znFromDb(flags[`FLAG_PSR_ZN_FROM_DB]),
        .psrOut(psrToController)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            xReg <= '0;
            yReg <= '0;
            accReg <= '0;
            spReg <= '0;
            aluHoldReg <= '0;
            ablReg <= '0;
            abhReg <= '0;
            dorReg <= '0;
            pcReg <= `PC_RESET;
        end else begin
            if (flags[`FLAG_LOAD_X]) xReg <= sbBus;
            if (flags[`FLAG_LOAD_Y]) yReg <= sbBus;
            if (flags[`FLAG_LOAD_ACC]) accReg <= sbBus;
            if (flags[`FLAG_LOAD_SP]) spReg <= sbBus;
            if (flags[`FLAG_LOAD_ALU]) aluHoldReg <= aluBus.result;
            if (flags[`FLAG_LOAD_ABL]) ablReg <= adlBus;
            if (flags[`FLAG_LOAD_ABH]) abhReg <= adhBus;
            if (flags[`FLAG_LOAD_DOR]) dorReg <= dbBus;
            // PC loads every cycle and takes a jump target from ADH:ADL
            pcReg <= flags[`FLAG_LOAD_PC] ? addrNext : pcNext;
        end
    end

    assign externalDBWrite = dorReg;
    assign addrLow = ablReg;
    assign addrHigh = abhReg;
    assign aluCarryOut = aluBus.carryOut;

endmodule

//--- src/processStatusRegister.sv
`include "cpu_params.svh"

module processStatusRegister (
    input logic clk,
    input logic arstN,
    aluIf.psr bus,
    input cpuPkg::dataByte_t dbIn,
    input logic loadAll,
    input logic cFromAlu,
    input logic vFromAlu,
    input logic znFromDb,
    output cpuPkg::dataByte_t psrOut
);

    // Bit layout N V 1 B D I Z C
    localparam int bitC = 0;
    localparam int bitZ = 1;
    localparam int bitV = 6;
    localparam int bitN = 7;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            psrOut <= `PSR_RESET;
        end else if (loadAll) begin
            psrOut <= dbIn | 8'h20; // Bit 5 reads as one
        end else begin
            if (cFromAlu) begin
                psrOut[bitC] <= bus.carryOut;
            end
            if (vFromAlu) begin
                psrOut[bitV] <= bus.overflow;
            end
            if (znFromDb) begin
                psrOut[bitZ] <= (dbIn == 8'h00);
                psrOut[bitN] <= dbIn[7];
            end
        end
    end

endmodule

//--- src/alu.sv
`include "cpu_params.svh"

module alu (
    aluIf.alu bus,
    input cpuPkg::dataByte_t dbIn,
    input cpuPkg::dataByte_t sbIn,
    input cpuPkg::dataByte_t adlIn,
    input logic aZero,
    input logic aFromSb,
    input logic bFromDb,
    input logic bFromNotDb,
    input logic bFromAdl
);
    import cpuPkg::*;

    dataByte_t aOperand;
    dataByte_t bOperand;
    logic [`DATA_WIDTH:0] sum; // Carry in the top bit

    // Operand latches behave like small buses, several selects AND together
    always_comb begin
        aOperand = '1;
        if (aFromSb) aOperand = aOperand & sbIn;
        if (aZero) aOperand = '0;
        bOperand = '1;
        if (bFromDb) bOperand = bOperand & dbIn;
        if (bFromNotDb) bOperand = bOperand & ~dbIn;
        if (bFromAdl) bOperand = bOperand & adlIn;
    end

    assign sum = {1'b0, aOperand} + {1'b0, bOperand} + {{`DATA_WIDTH{1'b0}}, bus.carryIn};

    always_comb begin
        bus.result = sum[`DATA_WIDTH-1:0];
        bus.carryOut = sum[`DATA_WIDTH];
        // Signed overflow when both inputs agree in sign and the sum does not
        bus.overflow = (aOperand[7] == bOperand[7]) && (sum[7] != aOperand[7]);
        case (bus.op)
            `ALU_OP_AND: begin
                bus.result = aOperand & bOperand;
                bus.carryOut = 1'b0;
                bus.overflow = 1'b0;
            end
            `ALU_OP_EOR: begin
                bus.result = aOperand ^ bOperand;
                bus.carryOut = 1'b0;
                bus.overflow = 1'b0;
            end
            `ALU_OP_OR: begin
                bus.result = aOperand | bOperand;
                bus.carryOut = 1'b0;
                bus.overflow = 1'b0;
            end
            `ALU_OP_SHR: begin
                bus.result = {bus.carryIn, aOperand[7:1]}; // Rotate through carry
                bus.carryOut = aOperand[0];
                bus.overflow = 1'b0;
            end
            default: ; // Add already computed above
        endcase
    end

endmodule

//--- src/programCounterLogic.sv
module programCounterLogic (
    input cpuPkg::pcWord_t pcIn,
    input logic increment,
    input logic decrement,
    output cpuPkg::pcWord_t pcOut
);

    // Increment has priority
    always_comb begin
        if (increment) begin
            pcOut = pcIn + 16'd1;
        end else if (decrement) begin
            pcOut = pcIn - 16'd1;
        end else begin
            pcOut = pcIn;
        end
    end

endmodule

//--- src/busBridge.sv
module busBridge (
    input cpuPkg::dataByte_t dbIn,
    input cpuPkg::dataByte_t sbIn,
    input cpuPkg::dataByte_t adhIn,
    output cpuPkg::dataByte_t dbOut,
    output cpuPkg::dataByte_t sbOut,
    output cpuPkg::dataByte_t adhOut,
    input logic dbToSb,
    input logic sbToDb,
    input logic sbToAdh,
    input logic adhToSb
);
    import cpuPkg::*;

    logic joinDbSb;
    logic joinSbAdh;
    dataByte_t sbMerged;

    // Pass gates are symmetric, direction does not matter
    assign joinDbSb = dbToSb | sbToDb;
    assign joinSbAdh = sbToAdh | adhToSb;

    // SB sits in the middle so it sees everything joined to it
    assign sbMerged = sbIn & (joinDbSb ? dbIn : '1) & (joinSbAdh ? adhIn : '1);

    assign sbOut = sbMerged;
    assign dbOut = joinDbSb ? sbMerged : dbIn;
    assign adhOut = joinSbAdh ? sbMerged : adhIn;

endmodule

//--- src/internalBus.sv
module internalBus #(
    parameter int sourceCount = 4
) (
    input logic [sourceCount-1:0] busSelect,
    input cpuPkg::dataByte_t [sourceCount-1:0] busInputs,
    output cpuPkg::dataByte_t busOutput
);

    // Precharged high, every enabled source can only pull bits low
    always_comb begin
        busOutput = '1;
        for (int i = 0; i < sourceCount; i++) begin
            if (busSelect[i]) begin
                busOutput = busOutput & busInputs[i];
            end
        end
    end

endmodule

//--- src/aluIf.sv
interface aluIf;
    import cpuPkg::*;

    aluOp_t op;
    logic carryIn;
    dataByte_t result;
    logic carryOut;
    logic overflow;

    // Datapath picks the op and carry in, takes the result back
    modport datapath(output op, carryIn, input result, carryOut);

    modport alu(input op, carryIn, output result, carryOut, overflow);

    // Status register only sees the flag outputs
    modport psr(input carryOut, overflow);

endinterface

//--- src/cpuPkg.sv
`include "cpu_params.svh"

package cpuPkg;

    // One byte on any internal bus or register
    typedef logic [`DATA_WIDTH-1:0] dataByte_t;

    // PCH in the upper byte, PCL in the lower
    typedef logic [2*`DATA_WIDTH-1:0] pcWord_t;

    // One bit per datapath function
    typedef logic [`NUM_FLAGS-1:0] ctrlWord_t;

    typedef logic [2:0] aluOp_t; // Encoded by the ALU_OP_* values

endpackage

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_WIDTH 8
// 60 distinct control bits are needed for the flag set below
`define NUM_FLAGS 60

// DB sources
`define FLAG_DB_FROM_DATA 0
`define FLAG_DB_FROM_ACC 1
`define FLAG_DB_FROM_PCL 2
`define FLAG_DB_FROM_PCH 3
`define FLAG_DB_FROM_PSR 4
// SB sources
`define FLAG_SB_FROM_X 5
`define FLAG_SB_FROM_Y 6
`define FLAG_SB_FROM_SP 7
`define FLAG_SB_FROM_ALU 8
`define FLAG_SB_FROM_ACC 9
// ADL and ADH sources
`define FLAG_ADL_FROM_DATA 10
`define FLAG_ADL_FROM_PCL 11
`define FLAG_ADL_FROM_ALU 12
`define FLAG_ADL_FROM_SP 13
`define FLAG_ADH_FROM_DATA 14
`define FLAG_ADH_FROM_PCH 15
// Bridge
`define FLAG_DB_TO_SB 16
`define FLAG_SB_TO_DB 17
`define FLAG_SB_TO_ADH 18
`define FLAG_ADH_TO_SB 19
// Presets
`define FLAG_DB_FF 20
`define FLAG_SB_FF 21
`define FLAG_ADL_FA 22
`define FLAG_ADL_FB 23
`define FLAG_ADL_FC 24
`define FLAG_ADL_FD 25
`define FLAG_ADL_FE 26
`define FLAG_ADL_FF 27
`define FLAG_ADL_00 28
`define FLAG_ADH_00 29
`define FLAG_ADH_01 30
`define FLAG_ADH_FF 31
// Register loads
`define FLAG_LOAD_X 32
`define FLAG_LOAD_Y 33
`define FLAG_LOAD_ACC 34
`define FLAG_LOAD_SP 35
`define FLAG_LOAD_ALU 36
`define FLAG_LOAD_ABL 37
`define FLAG_LOAD_ABH 38
`define FLAG_LOAD_DOR 39
`define FLAG_LOAD_PC 40
`define FLAG_PC_INC 41
`define FLAG_PC_DEC 42
// ALU operand selects
`define FLAG_A_FROM_SB 43
`define FLAG_A_ZERO 44
`define FLAG_B_FROM_DB 45
`define FLAG_B_FROM_NOT_DB 46
`define FLAG_B_FROM_ADL 47
// ALU operations
`define FLAG_ALU_ADD 48
`define FLAG_ALU_AND 49
`define FLAG_ALU_EOR 50
`define FLAG_ALU_OR 51
`define FLAG_ALU_SHR 52
// Carry in
`define FLAG_CARRY_ONE 53
`define FLAG_CARRY_FREE 54
`define FLAG_CARRY_PSR 55
// PSR loads
`define FLAG_PSR_FROM_DB 56
`define FLAG_PSR_C_FROM_ALU 57
`define FLAG_PSR_V_FROM_ALU 58
`define FLAG_PSR_ZN_FROM_DB 59

`define ALU_OP_ADD 3'd0
`define ALU_OP_AND 3'd1
`define ALU_OP_EOR 3'd2
`define ALU_OP_OR 3'd3
`define ALU_OP_SHR 3'd4

`define PSR_RESET 8'h24 // I and bit 5 set
`define PC_RESET 16'hAABB

`endif
